// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       ?= tb_stopwatch_spi
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "STATUS: PASS"

clean:
	rm -rf $(OBJ_DIR)

// ==== verif/tb_stopwatch_spi.sv ====
// Stopwatch SPI driver testbench
`default_nettype none

module tb_stopwatch_spi
  import disp_pkg::*;
  ();

  localparam int NUM_ROWS     = 6;
  localparam int WORD_TIMEOUT = 1000;  // Cycles, longer than any queued word
  localparam int QUIET_CYCLES = 2000;  // Several frame lengths

  // One stimulus row, digits in word order
  typedef struct packed {
    logic        en;
    logic        rnd;   // Digits drawn at random
    logic [11:0] hold;  // Tick high time in cycles
    digit_t      co, ct, so, st, mo, mt;
  } row_t;

  logic       clk = 1'b0;
  logic       rst_l;
  logic       tick;
  logic       en;
  logic [2:0] min_tens;
  logic [2:0] sec_tens;
  digit_t     min_ones;
  digit_t     sec_ones;
  digit_t     ces_tens;
  digit_t     ces_ones;
  logic       spi_clk;
  logic       spi_mosi;
  logic       spi_cs_n;
  logic       cs_prev = 1'b1;
  int         words_seen = 0;  // Chip-select low periods so far
  row_t       rows [NUM_ROWS];

  stopwatch_spi_top uut (
    .i_Clk      (clk),
    .i_Rst_L    (rst_l),
    .i_Tick     (tick),
    .i_En       (en),
    .i_min_tens (min_tens),
    .i_sec_tens (sec_tens),
    .i_min_ones (min_ones),
    .i_sec_ones (sec_ones),
    .i_ces_tens (ces_tens),
    .i_ces_ones (ces_ones),
    .o_SPI_Clk  (spi_clk),
    .o_SPI_MOSI (spi_mosi),
    .o_SPI_CS_n (spi_cs_n)
  );

  always #10 clk = ~clk;  // 20 unit period

  // Word counter, one count per CS fall
  always @(negedge clk)
  begin
    if (cs_prev && !spi_cs_n)
      words_seen <= words_seen + 1;
    cs_prev <= spi_cs_n;
  end

  ////////////////////////////////////////////////////////////
  // Checks and helpers

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("STATUS: FAIL");
    $fatal(1, "Simulation stopped on first error");
  endtask

  task automatic check_word(input byte_t got_addr, input byte_t got_data,
                            input byte_t exp_addr, input byte_t exp_data, input string what);
    if (got_addr !== exp_addr || got_data !== exp_data)
      stop_run($sformatf("MISMATCH at %0t: %s got %02h/%02h, expected %02h/%02h",
                         $time, what, got_addr, got_data, exp_addr, exp_data));
  endtask

  task automatic check_count(input int got, input int exp, input string what);
    if (got != exp)
      stop_run($sformatf("MISMATCH at %0t: %s got %0d, expected %0d", $time, what, got, exp));
  endtask

  task automatic apply_digits(input row_t d);
    ces_ones = d.co;
    ces_tens = d.ct;
    sec_ones = d.so;
    sec_tens = d.st[2:0];
    min_ones = d.mo;
    min_tens = d.mt[2:0];
  endtask

  // Collect one 16-bit word, MOSI taken at SPI clock rises seen on i_Clk falls
  task automatic receive_word(output byte_t addr, output byte_t data);
    logic [15:0] sr;
    logic        clk_prev;
    int          edges;
    int          n;
    n = 0;
    while (spi_cs_n !== 1'b0 && n < WORD_TIMEOUT)
    begin
      @(negedge clk);
      n++;
    end
    if (spi_cs_n !== 1'b0)
      stop_run("Timeout waiting for chip select to go low");
    sr       = '0;
    edges    = 0;
    n        = 0;
    clk_prev = spi_clk;
    while (spi_cs_n === 1'b0 && n < WORD_TIMEOUT)
    begin
      @(negedge clk);
      n++;
      if (spi_cs_n === 1'b0 && spi_clk === 1'b1 && clk_prev === 1'b0)
      begin
        sr    = {sr[14:0], spi_mosi};  // MSB arrives first
        edges = edges + 1;
      end
      clk_prev = spi_clk;
    end
    if (spi_cs_n !== 1'b1)
      stop_run("Timeout waiting for chip select to go high");
    check_count(edges, 16, "SPI clock rises in one chip-select period");
    addr = sr[15:8];
    data = sr[7:0];
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence

  initial
  begin
    row_t   row;
    row_t   alt;
    digit_t exp_dig [NUM_DIGITS];
    byte_t  got_addr;
    byte_t  got_data;
    int     start_cnt;
    void'($urandom(32'h1b9eb066));
    // en, rnd, hold, then ces ones/tens, sec ones/tens, min ones/tens
    rows = '{
      '{1'b1, 1'b0, 12'd4,    4'd3, 4'd7, 4'd2, 4'd4, 4'd9, 4'd5},
      '{1'b1, 1'b1, 12'd4,    4'd0, 4'd0, 4'd0, 4'd0, 4'd0, 4'd0},
      '{1'b0, 1'b0, 12'd4,    4'd1, 4'd1, 4'd1, 4'd1, 4'd1, 4'd1},  // Disabled tick
      '{1'b1, 1'b0, 12'd1200, 4'd9, 4'd9, 4'd9, 4'd5, 4'd9, 4'd5},  // Tick held high
      '{1'b1, 1'b1, 12'd6,    4'd0, 4'd0, 4'd0, 4'd0, 4'd0, 4'd0},
      '{1'b1, 1'b0, 12'd4,    4'd0, 4'd0, 4'd0, 4'd0, 4'd0, 4'd0}
    };
    rst_l = 1'b0;
    tick  = 1'b0;
    en    = 1'b0;
    apply_digits('0);
    repeat (3) @(negedge clk);
    if (spi_cs_n !== 1'b1)
      stop_run($sformatf("MISMATCH at %0t: chip select low during reset", $time));
    rst_l = 1'b1;

    // Decode-mode word comes first
    receive_word(got_addr, got_data);
    check_word(got_addr, got_data, 8'h09, 8'hFF, "setup word");

    for (int r = 0; r < NUM_ROWS; r++)
    begin
      row = rows[r];
      if (row.rnd)
      begin
        row.co = digit_t'($urandom % 10);
        row.ct = digit_t'($urandom % 10);
        row.so = digit_t'($urandom % 10);
        row.st = digit_t'($urandom % 6);
        row.mo = digit_t'($urandom % 10);
        row.mt = digit_t'($urandom % 6);
      end
      exp_dig = '{row.co, row.ct, row.so, row.st, row.mo, row.mt};
      alt     = row;  // Different legal digits for after the tick
      alt.co  = digit_t'((row.co + 1) % 10);
      alt.ct  = digit_t'((row.ct + 1) % 10);
      alt.so  = digit_t'((row.so + 1) % 10);
      alt.st  = digit_t'((row.st + 1) % 6);
      alt.mo  = digit_t'((row.mo + 1) % 10);
      alt.mt  = digit_t'((row.mt + 1) % 6);
      apply_digits(row);
      en = row.en;
      @(negedge clk);
      start_cnt = words_seen;
      tick      = 1'b1;
      fork
        begin
          repeat (row.hold) @(negedge clk);
          tick = 1'b0;
          apply_digits(alt);  // Frame must keep the captured time
        end
        begin
          if (row.en)
          begin
            for (int k = 0; k < NUM_DIGITS; k++)
            begin
              receive_word(got_addr, got_data);
              check_word(got_addr, got_data, byte_t'(k + 1), {4'h0, exp_dig[k]},
                         $sformatf("row %0d digit word %0d", r, k));
            end
          end
        end
      join
      repeat (QUIET_CYCLES) @(negedge clk);  // Catch extra words
      check_count(words_seen - start_cnt, row.en ? NUM_DIGITS : 0,
                  $sformatf("words after tick of row %0d", r));
    end

    $display("STATUS: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog/disp_pkg.sv ====
// Stopwatch display definitions
`default_nettype none

package disp_pkg;

  ////////////////////////////////////////////////////////////
  // Basic types

  typedef logic [7:0] byte_t;       // One SPI byte
  typedef logic [3:0] digit_t;      // One BCD digit
  typedef logic [2:0] digit_idx_t;  // Digit slot within a frame, 0 to 5

  // Digit words per display frame
  localparam int NUM_DIGITS = 6;

  ////////////////////////////////////////////////////////////
  // Seven-segment controller registers

  localparam byte_t ADDR_DECODE_MODE = 8'h09;  // Decode-mode register
  localparam byte_t DECODE_ALL_BCD   = 8'hFF;  // BCD decode on all 8 digits

  // First digit register, digit k sits at base + k
  localparam byte_t ADDR_DIGIT_BASE  = 8'h01;

  ////////////////////////////////////////////////////////////
  // SPI defaults

  // Mode 0 means CPOL 0 and CPHA 0
  localparam int DEF_SPI_MODE = 0;

  // i_Clk cycles per SPI half bit, must be 2 or more
  localparam int DEF_CLKS_PER_HALF_BIT = 2;

  // Cycles with chip select high between words, at least 1
  localparam int DEF_CS_INACTIVE_CLKS = 1;

endpackage

`default_nettype wire

// ==== verilog/disp_sequencer.sv ====
// Stopwatch display word sequencer
`default_nettype none

module disp_sequencer
  import disp_pkg::*;
  (
    input  wire logic       i_Clk,
    input  wire logic       i_Rst_L,
    input  wire logic       i_Tick,      // Display refresh tick async to i_Clk
    input  wire logic       i_En,        // Frame enable
    input  wire logic [2:0] i_min_tens,
    input  wire logic [2:0] i_sec_tens,
    input  wire digit_t     i_min_ones,
    input  wire digit_t     i_sec_ones,
    input  wire digit_t     i_ces_tens,
    input  wire digit_t     i_ces_ones,
    spi_word_if.src         word_o       // Words toward the CS controller
  );

  typedef enum logic [1:0] {
    SETUP = 2'd0,
    IDLE  = 2'd1,
    FRAME = 2'd2
  } seq_state_t;

  seq_state_t state;
  digit_idx_t digit_idx;               // Word being sent in the frame
  digit_t     snap [NUM_DIGITS];       // Time captured at frame start
  logic       tick_meta;
  logic       tick_sync;
  logic       tick_prev;
  logic       tick_rise;
  logic       start_frame;
  logic       word_xfer;

  ////////////////////////////////////////////////////////////
  // Tick synchronizer and edge detect

  always_ff @(posedge i_Clk or negedge i_Rst_L)
  begin
    if (!i_Rst_L)
    begin
      tick_meta <= 1'b0;
      tick_sync <= 1'b0;
      tick_prev <= 1'b0;
    end
    else
    begin
      tick_meta <= i_Tick;
      tick_sync <= tick_meta;
      tick_prev <= tick_sync;  // Previous synced level
    end
  end

  assign tick_rise   = tick_sync & ~tick_prev;
  assign start_frame = (state == IDLE) & tick_rise & i_En;  // Ticks in SETUP or FRAME drop
  assign word_xfer   = word_o.valid & word_o.ready;

  // Snapshot so one frame never mixes two times
  always_ff @(posedge i_Clk)
  begin
    if (start_frame)
    begin
      snap[0] <= i_ces_ones;
      snap[1] <= i_ces_tens;
      snap[2] <= i_sec_ones;
      snap[3] <= {1'b0, i_sec_tens};  // Tens of seconds only reach 5
      snap[4] <= i_min_ones;
      snap[5] <= {1'b0, i_min_tens};  // Tens of minutes only reach 5
    end
  end

  ////////////////////////////////////////////////////////////
  // Sequencer FSM

  always_ff @(posedge i_Clk or negedge i_Rst_L)
  begin
    if (!i_Rst_L)
    begin
      state        <= SETUP;
      word_o.valid <= 1'b0;
      digit_idx    <= '0;
    end
    else
    begin
      case (state)
        SETUP:
        begin
          if (!word_o.valid)
            word_o.valid <= 1'b1;  // Offer decode-mode word once
          else if (word_xfer)
          begin
            word_o.valid <= 1'b0;
            state        <= IDLE;
          end
        end
        IDLE:
        begin
          if (start_frame)
          begin
            digit_idx <= '0;
            state     <= FRAME;
          end
        end
        FRAME:
        begin
          if (!word_o.valid)
            word_o.valid <= 1'b1;
          else if (word_xfer)
          begin
            word_o.valid <= 1'b0;
            if (digit_idx == digit_idx_t'(NUM_DIGITS - 1))
              state <= IDLE;  // Last digit taken
            else
              digit_idx <= digit_idx + 1'b1;
          end
        end
        default:
        begin
          word_o.valid <= 1'b0;
          state        <= IDLE;
        end
      endcase
    end
  end

  // Payload follows state and index that hold while valid is up
  assign word_o.addr = (state == SETUP) ? ADDR_DECODE_MODE
                                        : ADDR_DIGIT_BASE + byte_t'(digit_idx);
  assign word_o.data = (state == SETUP) ? DECODE_ALL_BCD
                                        : {4'h0, snap[digit_idx]};  // Zero-extend digit

endmodule

`default_nettype wire

// ==== verilog/spi_cs_ctrl.sv ====
// SPI chip-select word framing
`default_nettype none

module spi_cs_ctrl
  import disp_pkg::*;
  #(
    parameter int CS_INACTIVE_CLKS = DEF_CS_INACTIVE_CLKS
  )
  (
    input  wire logic i_Clk,
    input  wire logic i_Rst_L,
    spi_word_if.dst   word_i,      // Incoming address/data words
    output byte_t     o_tx_byte,   // Byte for the shifter
    output logic      o_tx_start,  // One-cycle shifter start
    input  wire logic i_tx_ready,  // Shifter idle
    output logic      o_SPI_CS_n
  );

  localparam int CNT_W = $clog2(CS_INACTIVE_CLKS + 1);

  typedef enum logic [1:0] {
    IDLE = 2'd0,
    ADDR = 2'd1,
    DATA = 2'd2,
    HOLD = 2'd3
  } cs_state_t;

  cs_state_t        state;
  logic [CNT_W-1:0] hold_cnt;     // Remaining CS-high cycles
  byte_t            data_q;       // Data byte parked during address shift
  logic             word_xfer;
  logic             shift_done;   // Shifter back after our last start

  assign word_i.ready = (state == IDLE) & i_tx_ready;
  assign word_xfer    = word_i.valid & word_i.ready;
  assign shift_done   = i_tx_ready & ~o_tx_start;  // Ready still high in the start cycle

  // Byte payload toward the shifter
  always_ff @(posedge i_Clk)
  begin
    if (word_xfer)
    begin
      o_tx_byte <= word_i.addr;  // Address goes first
      data_q    <= word_i.data;
    end
    else if (state == ADDR && shift_done)
      o_tx_byte <= data_q;
  end

  ////////////////////////////////////////////////////////////
  // CS FSM

  always_ff @(posedge i_Clk or negedge i_Rst_L)
  begin
    if (!i_Rst_L)
    begin
      state      <= IDLE;
      o_SPI_CS_n <= 1'b1;
      o_tx_start <= 1'b0;
      hold_cnt   <= '0;
    end
    else
    begin
      o_tx_start <= 1'b0;  // Pulse only
      case (state)
        IDLE:
        begin
          if (word_xfer)
          begin
            o_SPI_CS_n <= 1'b0;
            o_tx_start <= 1'b1;
            state      <= ADDR;
          end
        end
        ADDR:
        begin
          if (shift_done)
          begin
            o_tx_start <= 1'b1;  // Data byte, CS stays low
            state      <= DATA;
          end
        end
        DATA:
        begin
          if (shift_done)
          begin
            o_SPI_CS_n <= 1'b1;  // Word complete
            hold_cnt   <= CNT_W'(CS_INACTIVE_CLKS - 1);
            state      <= HOLD;
          end
        end
        HOLD:
        begin
          if (hold_cnt == '0)
            state <= IDLE;
          else
            hold_cnt <= hold_cnt - 1'b1;
        end
        default:
        begin
          o_SPI_CS_n <= 1'b1;
          state      <= IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== verilog/spi_shift_engine.sv ====
// SPI clock and MOSI shifter
`default_nettype none

module spi_shift_engine
  import disp_pkg::*;
  #(
    parameter int SPI_MODE          = DEF_SPI_MODE,
    parameter int CLKS_PER_HALF_BIT = DEF_CLKS_PER_HALF_BIT
  )
  (
    input  wire logic i_Clk,
    input  wire logic i_Rst_L,
    input  wire byte_t i_tx_byte,  // Byte to send, MSB first
    input  wire logic i_tx_start,  // Start pulse, only while ready
    output logic      o_tx_ready,
    output logic      o_SPI_Clk,
    output logic      o_SPI_MOSI
  );

  localparam int CNT_W = $clog2(CLKS_PER_HALF_BIT * 2);

  // Idle level and data phase from the mode number
  localparam logic CPOL = (SPI_MODE == 2) || (SPI_MODE == 3);
  localparam logic CPHA = (SPI_MODE == 1) || (SPI_MODE == 3);

  logic [CNT_W-1:0] r_clk_count;    // Position inside one SPI bit
  logic [4:0]       r_clk_edges;    // Edges still to produce
  logic             r_spi_clk;
  logic             r_lead_edge;
  logic             r_trail_edge;
  logic             r_tx_start;     // Start delayed to match the byte register
  byte_t            r_tx_byte;
  logic [2:0]       r_bit_idx;      // Next bit to drive
  logic             shift_edge;

  ////////////////////////////////////////////////////////////
  // SPI clock edge generation

  always_ff @(posedge i_Clk or negedge i_Rst_L)
  begin
    if (!i_Rst_L)
    begin
      o_tx_ready   <= 1'b0;
      r_clk_edges  <= '0;
      r_lead_edge  <= 1'b0;
      r_trail_edge <= 1'b0;
      r_spi_clk    <= CPOL;  // Idle level
      r_clk_count  <= '0;
    end
    else
    begin
      r_lead_edge  <= 1'b0;
      r_trail_edge <= 1'b0;
      if (i_tx_start)
      begin
        o_tx_ready  <= 1'b0;
        r_clk_edges <= 5'd16;  // Two edges per bit
      end
      else if (r_clk_edges != '0)
      begin
        o_tx_ready <= 1'b0;
        if (r_clk_count == CNT_W'(CLKS_PER_HALF_BIT * 2 - 1))
        begin
          r_clk_edges  <= r_clk_edges - 1'b1;
          r_trail_edge <= 1'b1;
          r_clk_count  <= '0;
          r_spi_clk    <= ~r_spi_clk;
        end
        else if (r_clk_count == CNT_W'(CLKS_PER_HALF_BIT - 1))
        begin
          r_clk_edges <= r_clk_edges - 1'b1;
          r_lead_edge <= 1'b1;
          r_clk_count <= r_clk_count + 1'b1;
          r_spi_clk   <= ~r_spi_clk;
        end
        else
          r_clk_count <= r_clk_count + 1'b1;
      end
      else
        o_tx_ready <= 1'b1;  // All 16 edges out
    end
  end

  // Local copy of the byte
  always_ff @(posedge i_Clk)
  begin
    if (i_tx_start)
      r_tx_byte <= i_tx_byte;
  end

  always_ff @(posedge i_Clk or negedge i_Rst_L)
  begin
    if (!i_Rst_L)
      r_tx_start <= 1'b0;
    else
      r_tx_start <= i_tx_start;
  end

  ////////////////////////////////////////////////////////////
  // MOSI shifter

  // CPHA 0 changes data on trailing edges, CPHA 1 on leading edges
  assign shift_edge = (r_lead_edge & CPHA) | (r_trail_edge & ~CPHA);

  always_ff @(posedge i_Clk or negedge i_Rst_L)
  begin
    if (!i_Rst_L)
    begin
      o_SPI_MOSI <= 1'b0;
      r_bit_idx  <= 3'd7;
    end
    else if (o_tx_ready)
      r_bit_idx <= 3'd7;  // Rearm for next byte
    else if (r_tx_start & ~CPHA)
    begin
      o_SPI_MOSI <= r_tx_byte[7];  // First bit before the first edge
      r_bit_idx  <= 3'd6;
    end
    else if (shift_edge)
    begin
      o_SPI_MOSI <= r_tx_byte[r_bit_idx];
      r_bit_idx  <= r_bit_idx - 1'b1;
    end
  end

  // One register on the clock lines it up with MOSI
  always_ff @(posedge i_Clk or negedge i_Rst_L)
  begin
    if (!i_Rst_L)
      o_SPI_Clk <= CPOL;
    else
      o_SPI_Clk <= r_spi_clk;
  end

endmodule

`default_nettype wire

// ==== verilog/spi_word_if.sv ====
// Display word handshake
`default_nettype none

interface spi_word_if
  import disp_pkg::*;
  ();

  logic  valid;  // Word offered, held until taken
  logic  ready;  // CS controller can take a word
  byte_t addr;   // Register address byte
  byte_t data;   // Register data byte

  // Word producer side
  modport src (
    output valid,
    output addr,
    output data,
    input  ready
  );

  // Word consumer side
  modport dst (
    input  valid,
    input  addr,
    input  data,
    output ready
  );

endinterface

`default_nettype wire

// ==== verilog/stopwatch_spi_top.sv ====
// Stopwatch SPI display driver
`default_nettype none

module stopwatch_spi_top
  import disp_pkg::*;
  #(
    parameter int SPI_MODE          = DEF_SPI_MODE,
    parameter int CLKS_PER_HALF_BIT = DEF_CLKS_PER_HALF_BIT,
    parameter int CS_INACTIVE_CLKS  = DEF_CS_INACTIVE_CLKS
  )
  (
    input  wire logic       i_Clk,
    input  wire logic       i_Rst_L,
    input  wire logic       i_Tick,      // Refresh tick
    input  wire logic       i_En,
    input  wire logic [2:0] i_min_tens,
    input  wire logic [2:0] i_sec_tens,
    input  wire digit_t     i_min_ones,
    input  wire digit_t     i_sec_ones,
    input  wire digit_t     i_ces_tens,
    input  wire digit_t     i_ces_ones,
    output logic            o_SPI_Clk,
    output logic            o_SPI_MOSI,
    output logic            o_SPI_CS_n
  );

  spi_word_if word_bus ();  // Sequencer to CS controller

  byte_t tx_byte;
  logic  tx_start;
  logic  tx_ready;

  // Word source
  disp_sequencer u_seq (
    .i_Clk      (i_Clk),
    .i_Rst_L    (i_Rst_L),
    .i_Tick     (i_Tick),
    .i_En       (i_En),
    .i_min_tens (i_min_tens),
    .i_sec_tens (i_sec_tens),
    .i_min_ones (i_min_ones),
    .i_sec_ones (i_sec_ones),
    .i_ces_tens (i_ces_tens),
    .i_ces_ones (i_ces_ones),
    .word_o     (word_bus.src)
  );

  // Two-byte framing
  spi_cs_ctrl #(
    .CS_INACTIVE_CLKS (CS_INACTIVE_CLKS)
  ) u_cs (
    .i_Clk      (i_Clk),
    .i_Rst_L    (i_Rst_L),
    .word_i     (word_bus.dst),
    .o_tx_byte  (tx_byte),
    .o_tx_start (tx_start),
    .i_tx_ready (tx_ready),
    .o_SPI_CS_n (o_SPI_CS_n)
  );

  spi_shift_engine #(
    .SPI_MODE          (SPI_MODE),
    .CLKS_PER_HALF_BIT (CLKS_PER_HALF_BIT)
  ) u_shift (
    .i_Clk      (i_Clk),
    .i_Rst_L    (i_Rst_L),
    .i_tx_byte  (tx_byte),
    .i_tx_start (tx_start),
    .o_tx_ready (tx_ready),
    .o_SPI_Clk  (o_SPI_Clk),
    .o_SPI_MOSI (o_SPI_MOSI)
  );

endmodule

`default_nettype wire

// ==== vlog.f ====
verilog/disp_pkg.sv
verilog/spi_word_if.sv
verilog/disp_sequencer.sv
verilog/spi_cs_ctrl.sv
verilog/spi_shift_engine.sv
verilog/stopwatch_spi_top.sv
verif/tb_stopwatch_spi.sv
